//--- run.sh
#!/usr/bin/env bash
# build and run the LSU testbench with Verilator

verilator --binary --timing --assert --top-module lsu_tb -f verilog.f -o lsu_sim \
    && ./obj_dir/lsu_sim | tee /dev/stderr | grep -q "^TEST PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- source/exc_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module exc_tracker
    import lsu_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire load_wb_t   ld_wb_i,
    input  wire store_out_t st_out_i,
    input  wire redirect_t  flush_i,
    output logic            exc_valid_o,
    output rob_idx_t        exc_rob_o,
    output logic [XLEN-1:0] exc_vaddr_o
);
    logic            ld_exc;
    logic            st_exc;
    logic            cand_valid;
    rob_idx_t        cand_rob;
    logic [XLEN-1:0] cand_vaddr;
    logic            rec_kill;
    logic            take;

    assign ld_exc = ld_wb_i.valid && (ld_wb_i.exc == EXC_LD_MISALIGN);
    assign st_exc = st_out_i.valid && (st_out_i.exc == EXC_ST_MISALIGN);

    // pick the older of the two lanes
    always_comb begin
        cand_valid = ld_exc || st_exc;
        if (ld_exc && (!st_exc || rob_older(ld_wb_i.rob, st_out_i.rob))) begin
            cand_rob   = ld_wb_i.rob;
            cand_vaddr = ld_wb_i.data;
        end else begin
            cand_rob   = st_out_i.rob;
            cand_vaddr = st_out_i.data;
        end
    end

    assign rec_kill = exc_valid_o && flush_kills(flush_i, exc_rob_o);
    assign take     = cand_valid && !flush_kills(flush_i, cand_rob)
                      && (!exc_valid_o || rob_older(cand_rob, exc_rob_o));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exc_valid_o <= 1'b0;
        end else if (take) begin
            exc_valid_o <= 1'b1;
        end else if (rec_kill) begin
            exc_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            exc_rob_o   <= cand_rob;
            exc_vaddr_o <= cand_vaddr;
        end
    end

endmodule

`default_nettype wire

//--- source/load_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module load_pipe
    import lsu_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire mem_req_t      req_i,
    input  wire redirect_t     flush_i,
    input  wire [XLEN-1:0]     dmem_rdata_i,
    output logic               dmem_req_o,
    output logic [WADDR_W-1:0] dmem_addr_o,
    output probe_t             s1_probe_o,
    output probe_t             s2_probe_o,
    output load_wb_t           wb_o
);
    access_t           acc;
    logic              s1_valid;
    rob_idx_t          s1_rob;
    size_e             s1_size;
    logic              s1_uext;
    access_t           s1_acc;
    logic              s1_kill;
    logic              s2_valid;
    rob_idx_t          s2_rob;
    size_e             s2_size;
    logic              s2_uext;
    access_t           s2_acc;
    logic              s2_kill;
    logic [2*XLEN-1:0] dbl;
    logic [XLEN-1:0]   rot;
    logic [XLEN-1:0]   ext;
    logic              wb_valid;
    rob_idx_t          wb_rob;
    logic [XLEN-1:0]   wb_data;
    exc_e              wb_exc;

    mem_access_decode u_decode (
        .base_i (req_i.base),
        .imm_i  (req_i.imm),
        .size_i (req_i.size),
        .acc_o  (acc)
    );

    assign s1_kill = flush_kills(flush_i, s1_rob);
    assign s2_kill = flush_kills(flush_i, s2_rob);

    // misaligned loads never reach memory
    assign dmem_req_o  = s1_valid && !s1_acc.misalign && !s1_kill;
    assign dmem_addr_o = s1_acc.waddr;

    assign s1_probe_o = '{valid: s1_valid && !s1_acc.misalign, waddr: s1_acc.waddr,
                          mask: s1_acc.mask, rob: s1_rob};
    assign s2_probe_o = '{valid: s2_valid && !s2_acc.misalign, waddr: s2_acc.waddr,
                          mask: s2_acc.mask, rob: s2_rob};

    // bring the addressed byte down to lane 0
    assign dbl = {dmem_rdata_i, dmem_rdata_i} >> {s2_acc.vaddr[OFF_W-1:0], 3'b000};
    assign rot = dbl[XLEN-1:0];

    always_comb begin
        case (s2_size)
            SZ_BYTE: ext = {{(XLEN-8){!s2_uext && rot[7]}}, rot[7:0]};
            SZ_HALF: ext = {{(XLEN-16){!s2_uext && rot[15]}}, rot[15:0]};
            default: ext = rot;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s1_valid <= req_i.valid && !flush_kills(flush_i, req_i.rob);
            s2_valid <= s1_valid && !s1_kill;
            wb_valid <= s2_valid && !s2_kill;
        end
    end

    always_ff @(posedge clk) begin
        s1_rob  <= req_i.rob;
        s1_size <= req_i.size;
        s1_uext <= req_i.uext;
        s1_acc  <= acc;
        s2_rob  <= s1_rob;
        s2_size <= s1_size;
        s2_uext <= s1_uext;
        s2_acc  <= s1_acc;
        wb_rob  <= s2_rob;
        if (s2_acc.misalign) begin
            wb_data <= s2_acc.vaddr;
            wb_exc  <= EXC_LD_MISALIGN;
        end else begin
            wb_data <= ext;
            wb_exc  <= EXC_NONE;
        end
    end

    assign wb_o = '{valid: wb_valid, rob: wb_rob, data: wb_data, exc: wb_exc};

endmodule

`default_nettype wire

//--- source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int XLEN    = 32;
    localparam int BYTES   = 4;
    localparam int OFF_W   = 2;
    localparam int ROB_W   = 5;
    localparam int WADDR_W = XLEN - OFF_W;

    typedef struct packed {
        logic             wrap;
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } size_e;

    typedef enum logic [1:0] {
        EXC_NONE        = 2'b00,
        EXC_LD_MISALIGN = 2'b01,
        EXC_ST_MISALIGN = 2'b10
    } exc_e;

    // one issued operation from the issue stage
    typedef struct packed {
        logic            valid;
        rob_idx_t        rob;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] imm;
        size_e           size;
        logic            uext;
        logic [XLEN-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0]    vaddr;
        logic [WADDR_W-1:0] waddr;
        logic [BYTES-1:0]   mask;
        logic               misalign;
    } access_t;

    typedef struct packed {
        logic               valid;
        logic [WADDR_W-1:0] waddr;
        logic [BYTES-1:0]   mask;
        rob_idx_t           rob;
    } probe_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob;
    } redirect_t;

    // on a misaligned load, data carries the faulting virtual address
    typedef struct packed {
        logic            valid;
        rob_idx_t        rob;
        logic [XLEN-1:0] data;
        exc_e            exc;
    } load_wb_t;

    // on a misaligned store, mask is zero and data carries the virtual address
    typedef struct packed {
        logic               valid;
        rob_idx_t           rob;
        logic [WADDR_W-1:0] waddr;
        logic [BYTES-1:0]   mask;
        logic [XLEN-1:0]    data;
        exc_e               exc;
    } store_out_t;

    // true when a is older than b
    function automatic logic rob_older(rob_idx_t a, rob_idx_t b);
        if (a.wrap == b.wrap) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

    // flush removes everything younger than its index
    function automatic logic flush_kills(redirect_t f, rob_idx_t r);
        return f.valid && rob_older(f.rob, r);
    endfunction

endpackage

`default_nettype wire

//--- source/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire mem_req_t      ld_req_i,
    input  wire mem_req_t      st_req_i,
    input  wire redirect_t     flush_i,
    input  wire [XLEN-1:0]     dmem_rdata_i,
    output logic               dmem_req_o,
    output logic [WADDR_W-1:0] dmem_addr_o,
    output load_wb_t           ld_wb_o,
    output store_out_t         st_out_o,
    output redirect_t          mem_redirect_o,
    output logic               exc_valid_o,
    output rob_idx_t           exc_rob_o,
    output logic [XLEN-1:0]    exc_vaddr_o
);
    probe_t ld_s1_probe;
    probe_t ld_s2_probe;
    probe_t st_probe;

    load_pipe u_load_pipe (
        .clk          (clk),
        .rst          (rst),
        .req_i        (ld_req_i),
        .flush_i      (flush_i),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_addr_o  (dmem_addr_o),
        .s1_probe_o   (ld_s1_probe),
        .s2_probe_o   (ld_s2_probe),
        .wb_o         (ld_wb_o)
    );

    store_pipe u_store_pipe (
        .clk     (clk),
        .rst     (rst),
        .req_i   (st_req_i),
        .flush_i (flush_i),
        .probe_o (st_probe),
        .out_o   (st_out_o)
    );

    // store stage 1 against both load stages
    violation_check u_violation_check (
        .clk           (clk),
        .rst           (rst),
        .st_probe_i    (st_probe),
        .ld_s1_probe_i (ld_s1_probe),
        .ld_s2_probe_i (ld_s2_probe),
        .flush_i       (flush_i),
        .redirect_o    (mem_redirect_o)
    );

    exc_tracker u_exc_tracker (
        .clk         (clk),
        .rst         (rst),
        .ld_wb_i     (ld_wb_o),
        .st_out_i    (st_out_o),
        .flush_i     (flush_i),
        .exc_valid_o (exc_valid_o),
        .exc_rob_o   (exc_rob_o),
        .exc_vaddr_o (exc_vaddr_o)
    );

endmodule

`default_nettype wire

//--- source/mem_access_decode.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access_decode
    import lsu_pkg::*;
(
    input  wire [XLEN-1:0] base_i,
    input  wire [XLEN-1:0] imm_i,
    input  wire size_e     size_i,
    output access_t        acc_o
);
    logic [XLEN-1:0]  vaddr;
    logic [OFF_W-1:0] off;

    assign vaddr = base_i + imm_i;
    assign off   = vaddr[OFF_W-1:0];

    always_comb begin
        acc_o.vaddr = vaddr;
        acc_o.waddr = vaddr[XLEN-1:OFF_W];
        case (size_i)
            SZ_WORD: begin
                acc_o.mask     = 4'b1111;
                acc_o.misalign = off != 2'b00;
            end
            SZ_HALF: begin
                acc_o.mask     = 4'b0011 << off;
                acc_o.misalign = off[0];
            end
            default: begin
                acc_o.mask     = 4'b0001 << off;
                acc_o.misalign = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/store_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module store_pipe
    import lsu_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire mem_req_t  req_i,
    input  wire redirect_t flush_i,
    output probe_t         probe_o,
    output store_out_t     out_o
);
    access_t            acc;
    logic               s1_valid;
    rob_idx_t           s1_rob;
    size_e              s1_size;
    logic [XLEN-1:0]    s1_data;
    access_t            s1_acc;
    logic [XLEN-1:0]    lanes;
    logic [XLEN-1:0]    lane_bits;
    logic               out_valid;
    rob_idx_t           out_rob;
    logic [WADDR_W-1:0] out_waddr;
    logic [BYTES-1:0]   out_mask;
    logic [XLEN-1:0]    out_data;
    exc_e               out_exc;

    mem_access_decode u_decode (
        .base_i (req_i.base),
        .imm_i  (req_i.imm),
        .size_i (req_i.size),
        .acc_o  (acc)
    );

    assign probe_o = '{valid: s1_valid && !s1_acc.misalign, waddr: s1_acc.waddr,
                       mask: s1_acc.mask, rob: s1_rob};

    // copy the low bytes across the word, then keep the masked lanes
    always_comb begin
        case (s1_size)
            SZ_BYTE: lanes = {BYTES{s1_data[7:0]}};
            SZ_HALF: lanes = {(BYTES/2){s1_data[15:0]}};
            default: lanes = s1_data;
        endcase
        for (int i = 0; i < BYTES; i++) begin
            lane_bits[8*i +: 8] = {8{s1_acc.mask[i]}};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= req_i.valid && !flush_kills(flush_i, req_i.rob);
            out_valid <= s1_valid && !flush_kills(flush_i, s1_rob);
        end
    end

    always_ff @(posedge clk) begin
        s1_rob    <= req_i.rob;
        s1_size   <= req_i.size;
        s1_data   <= req_i.data;
        s1_acc    <= acc;
        out_rob   <= s1_rob;
        out_waddr <= s1_acc.waddr;
        if (s1_acc.misalign) begin
            out_mask <= '0;
            out_data <= s1_acc.vaddr;
            out_exc  <= EXC_ST_MISALIGN;
        end else begin
            out_mask <= s1_acc.mask;
            out_data <= lanes & lane_bits;
            out_exc  <= EXC_NONE;
        end
    end

    assign out_o = '{valid: out_valid, rob: out_rob, waddr: out_waddr, mask: out_mask,
                     data: out_data, exc: out_exc};

endmodule

`default_nettype wire

//--- source/violation_check.sv
`timescale 1ns/1ns
`default_nettype none

module violation_check
    import lsu_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire probe_t    st_probe_i,
    input  wire probe_t    ld_s1_probe_i,
    input  wire probe_t    ld_s2_probe_i,
    input  wire redirect_t flush_i,
    output redirect_t      redirect_o
);
    logic     s1_hit;
    logic     s2_hit;
    logic     sel_valid;
    rob_idx_t sel_rob;
    logic     red_valid;
    rob_idx_t red_rob;

    // younger load touching a byte the store writes
    function automatic logic hits(probe_t st, probe_t ld);
        logic same_word;
        same_word = st.waddr == ld.waddr;
        return st.valid && ld.valid && same_word && (|(st.mask & ld.mask))
               && rob_older(st.rob, ld.rob);
    endfunction

    assign s1_hit = hits(st_probe_i, ld_s1_probe_i);
    assign s2_hit = hits(st_probe_i, ld_s2_probe_i);

    // the older load is where execution restarts
    always_comb begin
        sel_valid = s1_hit || s2_hit;
        if (s1_hit && (!s2_hit || rob_older(ld_s1_probe_i.rob, ld_s2_probe_i.rob))) begin
            sel_rob = ld_s1_probe_i.rob;
        end else begin
            sel_rob = ld_s2_probe_i.rob;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red_valid <= 1'b0;
        end else begin
            red_valid <= sel_valid && !flush_kills(flush_i, sel_rob);
        end
    end

    always_ff @(posedge clk) begin
        red_rob <= sel_rob;
    end

    assign redirect_o = '{valid: red_valid, rob: red_rob};

endmodule

`default_nettype wire

//--- test/lsu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_properties
    import lsu_pkg::*;
(
    input wire                clk,
    input wire                rst,
    input wire mem_req_t      ld_req_i,
    input wire mem_req_t      st_req_i,
    input wire redirect_t     flush_i,
    input wire [XLEN-1:0]     dmem_rdata_i,
    input wire                dmem_req_o,
    input wire [WADDR_W-1:0]  dmem_addr_o,
    input wire load_wb_t      ld_wb_o,
    input wire store_out_t    st_out_o,
    input wire redirect_t     mem_redirect_o,
    input wire                exc_valid_o,
    input wire rob_idx_t      exc_rob_o,
    input wire [XLEN-1:0]     exc_vaddr_o
);
    int              fails = 0;
    mem_req_t        ld_h1, ld_h2, ld_h3;
    mem_req_t        st_h1, st_h2;
    redirect_t       fl_h1, fl_h2, fl_h3;
    logic [XLEN-1:0] rd_h1;
    logic            exp_req;
    load_wb_t        exp_wb;
    store_out_t      exp_st;
    logic            m1, m2, st_ok;
    logic            exp_rd_valid;
    rob_idx_t        exp_rd_rob;
    logic            c_ld, c_st, c_valid, take;
    rob_idx_t        c_rob;
    logic [XLEN-1:0] c_vaddr;
    logic            m_valid;
    rob_idx_t        m_rob;
    logic [XLEN-1:0] m_vaddr;

    // a is older when b lies less than half the index space ahead of it
    function automatic logic is_older(rob_idx_t a, rob_idx_t b);
        logic [5:0] d;
        d = {b.wrap, b.idx} - {a.wrap, a.idx};
        return (d != 6'd0) && (d < 6'd32);
    endfunction

    function automatic logic kills(redirect_t f, rob_idx_t r);
        return f.valid && is_older(f.rob, r);
    endfunction

    function automatic logic [XLEN-1:0] va(mem_req_t r);
        return r.base + r.imm;
    endfunction

    function automatic logic bad(mem_req_t r);
        logic [1:0] off;
        off = 2'(va(r));
        case (r.size)
            SZ_WORD: return off != 2'b00;
            SZ_HALF: return off[0];
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] lane_mask(mem_req_t r);
        logic [1:0] off;
        off = 2'(va(r));
        case (r.size)
            SZ_BYTE: return 4'b0001 << off;
            SZ_HALF: return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] load_value(logic [XLEN-1:0] w, mem_req_t r);
        logic [1:0]      off;
        logic [XLEN-1:0] sh;
        off = 2'(va(r));
        sh  = w >> {off, 3'b000};
        case (r.size)
            SZ_BYTE: return r.uext ? {24'd0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            SZ_HALF: return r.uext ? {16'd0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] store_value(mem_req_t r);
        logic [1:0] off;
        off = 2'(va(r));
        case (r.size)
            SZ_BYTE: return {24'd0, r.data[7:0]} << {off, 3'b000};
            SZ_HALF: return {16'd0, r.data[15:0]} << {off, 3'b000};
            default: return r.data;
        endcase
    endfunction

    // load younger than store, same word, shared byte
    function automatic logic overlap(mem_req_t st, mem_req_t ld);
        return (va(st) >> 2) == (va(ld) >> 2) && (|(lane_mask(st) & lane_mask(ld)))
               && is_older(st.rob, ld.rob);
    endfunction

    // request and flush history, index = edges ago
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ld_h1 <= '0;
            ld_h2 <= '0;
            ld_h3 <= '0;
            st_h1 <= '0;
            st_h2 <= '0;
            fl_h1 <= '0;
            fl_h2 <= '0;
            fl_h3 <= '0;
            rd_h1 <= '0;
        end else begin
            ld_h1 <= ld_req_i;
            ld_h2 <= ld_h1;
            ld_h3 <= ld_h2;
            st_h1 <= st_req_i;
            st_h2 <= st_h1;
            fl_h1 <= flush_i;
            fl_h2 <= fl_h1;
            fl_h3 <= fl_h2;
            rd_h1 <= dmem_rdata_i;
        end
    end

    always_comb begin
        exp_req = ld_h1.valid && !kills(fl_h1, ld_h1.rob) && !kills(flush_i, ld_h1.rob)
                  && !bad(ld_h1);

        exp_wb.valid = ld_h3.valid && !kills(fl_h3, ld_h3.rob) && !kills(fl_h2, ld_h3.rob)
                       && !kills(fl_h1, ld_h3.rob);
        exp_wb.rob   = ld_h3.rob;
        exp_wb.data  = bad(ld_h3) ? va(ld_h3) : load_value(rd_h1, ld_h3);
        exp_wb.exc   = bad(ld_h3) ? EXC_LD_MISALIGN : EXC_NONE;

        exp_st.valid = st_h2.valid && !kills(fl_h2, st_h2.rob) && !kills(fl_h1, st_h2.rob);
        exp_st.rob   = st_h2.rob;
        exp_st.waddr = WADDR_W'(va(st_h2) >> 2);
        exp_st.mask  = bad(st_h2) ? 4'b0000 : lane_mask(st_h2);
        exp_st.data  = bad(st_h2) ? va(st_h2) : store_value(st_h2);
        exp_st.exc   = bad(st_h2) ? EXC_ST_MISALIGN : EXC_NONE;

        st_ok = st_h2.valid && !kills(fl_h2, st_h2.rob) && !bad(st_h2);
        m1 = st_ok && ld_h2.valid && !kills(fl_h2, ld_h2.rob) && !bad(ld_h2)
             && overlap(st_h2, ld_h2);
        m2 = st_ok && ld_h3.valid && !kills(fl_h3, ld_h3.rob) && !kills(fl_h2, ld_h3.rob)
             && !bad(ld_h3) && overlap(st_h2, ld_h3);
        exp_rd_rob   = (m1 && (!m2 || is_older(ld_h2.rob, ld_h3.rob))) ? ld_h2.rob : ld_h3.rob;
        exp_rd_valid = (m1 || m2) && !kills(fl_h1, exp_rd_rob);

        // oldest misaligned access among the expected outputs
        c_ld    = exp_wb.valid && exp_wb.exc == EXC_LD_MISALIGN;
        c_st    = exp_st.valid && exp_st.exc == EXC_ST_MISALIGN;
        c_valid = c_ld || c_st;
        if (c_ld && (!c_st || is_older(exp_wb.rob, exp_st.rob))) begin
            c_rob   = exp_wb.rob;
            c_vaddr = exp_wb.data;
        end else begin
            c_rob   = exp_st.rob;
            c_vaddr = exp_st.data;
        end
        take = c_valid && !kills(flush_i, c_rob) && (!m_valid || is_older(c_rob, m_rob));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_valid <= 1'b0;
            m_rob   <= '0;
            m_vaddr <= '0;
        end else if (take) begin
            m_valid <= 1'b1;
            m_rob   <= c_rob;
            m_vaddr <= c_vaddr;
        end else if (m_valid && kills(flush_i, m_rob)) begin
            m_valid <= 1'b0;
        end
    end

    a_dmem_req: assert property (@(posedge clk) disable iff (rst)
        dmem_req_o == exp_req)
        else begin
            fails++;
            $error("ERROR dmem_req expected %0d actual %0d", $sampled(exp_req),
                   $sampled(dmem_req_o));
        end

    a_dmem_addr: assert property (@(posedge clk) disable iff (rst)
        dmem_req_o |-> dmem_addr_o == WADDR_W'(va(ld_h1) >> 2))
        else begin
            fails++;
            $error("ERROR dmem_addr expected %h actual %h", $sampled(va(ld_h1) >> 2),
                   $sampled(dmem_addr_o));
        end

    a_ld_wb: assert property (@(posedge clk) disable iff (rst)
        (ld_wb_o.valid == exp_wb.valid) && (!exp_wb.valid || ld_wb_o == exp_wb))
        else begin
            fails++;
            $error("ERROR ld_wb expected %h actual %h", $sampled(exp_wb), $sampled(ld_wb_o));
        end

    a_st_out: assert property (@(posedge clk) disable iff (rst)
        (st_out_o.valid == exp_st.valid) && (!exp_st.valid || st_out_o == exp_st))
        else begin
            fails++;
            $error("ERROR st_out expected %h actual %h", $sampled(exp_st), $sampled(st_out_o));
        end

    a_redirect: assert property (@(posedge clk) disable iff (rst)
        (mem_redirect_o.valid == exp_rd_valid)
        && (!exp_rd_valid || mem_redirect_o.rob == exp_rd_rob))
        else begin
            fails++;
            $error("ERROR mem_redirect expected %0d/%h actual %h", $sampled(exp_rd_valid),
                   $sampled(exp_rd_rob), $sampled(mem_redirect_o));
        end

    a_exc: assert property (@(posedge clk) disable iff (rst)
        (exc_valid_o == m_valid)
        && (!m_valid || (exc_rob_o == m_rob && exc_vaddr_o == m_vaddr)))
        else begin
            fails++;
            $error("ERROR exc_record expected %0d/%h/%h actual %0d/%h/%h", $sampled(m_valid),
                   $sampled(m_rob), $sampled(m_vaddr), $sampled(exc_valid_o),
                   $sampled(exc_rob_o), $sampled(exc_vaddr_o));
        end

endmodule

bind lsu_top lsu_properties u_props (.*);

`default_nettype wire

//--- test/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();
    localparam int N_RAND     = 48;
    localparam int N_DIRECTED = 35;
    localparam int N_TAIL     = 6;
    localparam int RST_CYCLES = 5;
    localparam int LIMIT      = RST_CYCLES + N_DIRECTED + N_RAND + N_TAIL + 20;

    logic               clk;
    logic               rst;
    mem_req_t           ld_req;
    mem_req_t           st_req;
    redirect_t          flush;
    logic [XLEN-1:0]    dmem_rdata = '0;
    logic               dmem_req;
    logic [WADDR_W-1:0] dmem_addr;
    load_wb_t           ld_wb;
    store_out_t         st_out;
    redirect_t          mem_redirect;
    logic               exc_valid;
    rob_idx_t           exc_rob;
    logic [XLEN-1:0]    exc_vaddr;
    int                 seed = 32'h0d69_c301;
    int                 cycles = 0;
    logic [5:0]         rob_ctr = '0;
    logic               passed = 1'b0;
    logic               fail_shown = 1'b0;

    tb_clock u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    lsu_top uut (
        .clk            (clk),
        .rst            (rst),
        .ld_req_i       (ld_req),
        .st_req_i       (st_req),
        .flush_i        (flush),
        .dmem_rdata_i   (dmem_rdata),
        .dmem_req_o     (dmem_req),
        .dmem_addr_o    (dmem_addr),
        .ld_wb_o        (ld_wb),
        .st_out_o       (st_out),
        .mem_redirect_o (mem_redirect),
        .exc_valid_o    (exc_valid),
        .exc_rob_o      (exc_rob),
        .exc_vaddr_o    (exc_vaddr)
    );

    // memory contents depend on every address bit
    function automatic logic [XLEN-1:0] mem_word(logic [WADDR_W-1:0] a);
        return ({a, 2'b01} * 32'h9e37_79b1) ^ {a[13:0], a[29:12]};
    endfunction

    function automatic rob_idx_t rob_of(int v);
        return rob_idx_t'(v[5:0]);
    endfunction

    function automatic rob_idx_t next_rob();
        rob_idx_t r;
        r = rob_idx_t'(rob_ctr);
        rob_ctr = rob_ctr + 6'd1;
        return r;
    endfunction

    function automatic redirect_t flush_of(int v);
        return '{valid: 1'b1, rob: rob_of(v)};
    endfunction

    function automatic mem_req_t op(rob_idx_t rob, logic [3:0] word, logic [1:0] off,
                                    size_e size);
        mem_req_t r;
        r.valid = 1'b1;
        r.rob   = rob;
        r.base  = 32'h0000_0400 + {26'd0, word, 2'b00};
        r.imm   = {30'd0, off};
        r.size  = size;
        r.uext  = 1'b0;
        r.data  = $random(seed);
        return r;
    endfunction

    // mostly aligned, a few words only so that overlaps are common
    function automatic mem_req_t rand_op(rob_idx_t rob);
        logic [31:0] rnd;
        size_e       sz;
        logic [1:0]  off;
        mem_req_t    r;
        rnd = $random(seed);
        case (rnd[5:4])
            2'd0: sz = SZ_BYTE;
            2'd1: sz = SZ_HALF;
            default: sz = SZ_WORD;
        endcase
        off = rnd[3:2];
        if (rnd[7:6] != 2'b00) begin
            if (sz == SZ_WORD) begin
                off = 2'b00;
            end else if (sz == SZ_HALF) begin
                off[0] = 1'b0;
            end
        end
        r = op(rob, {2'b00, rnd[1:0]}, off, sz);
        r.uext = rnd[8];
        return r;
    endfunction

    task automatic drive(mem_req_t ld, mem_req_t st, redirect_t fl);
        @(posedge clk);
        ld_req <= ld;
        st_req <= st;
        flush  <= fl;
    endtask

    task automatic idle(int n);
        for (int i = 0; i < n; i++) begin
            drive('0, '0, '0);
        end
    endtask

    always @(posedge clk) begin
        if (dmem_req) begin
            dmem_rdata <= mem_word(dmem_addr);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            fail_shown = 1'b1;
            $display("TEST FAILED");
            $fatal(1, "timeout: run did not finish within %0d cycles", LIMIT);
        end
    end

    initial begin
        logic [31:0] rnd;
        rob_idx_t    a;
        rob_idx_t    b;
        mem_req_t    ld;
        mem_req_t    st;
        ld_req = '0;
        st_req = '0;
        flush  = '0;
        @(negedge rst);

        // misaligned accesses arriving youngest first
        drive(op(rob_of(6), 4'd1, 2'd1, SZ_WORD), op(rob_of(5), 4'd2, 2'd1, SZ_HALF), '0);
        drive(op(rob_of(3), 4'd3, 2'd3, SZ_HALF), op(rob_of(4), 4'd4, 2'd2, SZ_WORD), '0);
        drive(op(rob_of(1), 4'd5, 2'd3, SZ_WORD), op(rob_of(2), 4'd6, 2'd1, SZ_HALF), '0);
        idle(4);

        // flushes at stage 1, on the record, at stage 2 and on a redirect
        drive(op(rob_of(8), 4'd2, 2'd0, SZ_WORD), op(rob_of(9), 4'd3, 2'd0, SZ_WORD), '0);
        drive('0, '0, flush_of(7));
        drive('0, '0, flush_of(0));
        drive(op(rob_of(10), 4'd4, 2'd0, SZ_WORD), '0, '0);
        idle(1);
        drive('0, '0, flush_of(9));
        drive(op(rob_of(12), 4'd5, 2'd0, SZ_WORD), '0, '0);
        drive('0, op(rob_of(11), 4'd5, 2'd2, SZ_BYTE), '0);
        drive('0, '0, flush_of(11));
        // killed on the edge that samples them
        drive(op(rob_of(14), 4'd6, 2'd0, SZ_WORD), op(rob_of(15), 4'd7, 2'd0, SZ_WORD),
              flush_of(13));
        idle(4);

        // overlap against stage 2, stage 1 and both
        drive(op(rob_of(17), 4'd6, 2'd2, SZ_HALF), '0, '0);
        drive('0, op(rob_of(16), 4'd6, 2'd3, SZ_BYTE), '0);
        drive(op(rob_of(19), 4'd7, 2'd0, SZ_WORD), op(rob_of(18), 4'd7, 2'd0, SZ_BYTE), '0);
        drive(op(rob_of(21), 4'd8, 2'd1, SZ_BYTE), '0, '0);
        drive(op(rob_of(22), 4'd8, 2'd0, SZ_HALF), op(rob_of(20), 4'd8, 2'd0, SZ_WORD), '0);
        drive(op(rob_of(28), 4'd11, 2'd0, SZ_WORD), op(rob_of(27), 4'd11, 2'd2, SZ_BYTE), '0);
        // older load, then disjoint bytes
        drive(op(rob_of(23), 4'd9, 2'd0, SZ_WORD), '0, '0);
        drive('0, op(rob_of(24), 4'd9, 2'd0, SZ_WORD), '0);
        drive(op(rob_of(26), 4'd10, 2'd0, SZ_BYTE), '0, '0);
        drive('0, op(rob_of(25), 4'd10, 2'd1, SZ_BYTE), '0);
        idle(4);

        rob_ctr = 6'd32;
        for (int i = 0; i < N_RAND; i++) begin
            rnd = $random(seed);
            a   = next_rob();
            b   = next_rob();
            ld  = '0;
            st  = '0;
            if (rnd[0]) begin
                ld = rand_op(rnd[2] ? a : b);
            end
            if (rnd[1]) begin
                st = rand_op(rnd[2] ? b : a);
            end
            drive(ld, st, '0);
        end
        idle(N_TAIL);

        if (uut.u_props.fails == 0) begin
            passed = 1'b1;
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_shown = 1'b1;
            $display("TEST FAILED");
            $fatal(1, "%0d assertion failures", uut.u_props.fails);
        end
    end

    final begin
        if (!passed && !fail_shown) begin
            $display("TEST FAILED");
        end
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);
    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verilog.f
source/lsu_pkg.sv
source/mem_access_decode.sv
source/load_pipe.sv
source/store_pipe.sv
source/violation_check.sv
source/exc_tracker.sv
source/lsu_top.sv
test/tb_clock.sv
test/lsu_properties.sv
test/lsu_tb.sv
